// ==== Bender.yml ====
package:
  name: gcm_tag_engine

sources:
  - files:
      - rtl/gcm_types_pkg.sv
      - rtl/gcm_ctrl_pkg.sv
      - rtl/gf128_multiplier.sv
      - rtl/ghash_accumulator.sv
      - rtl/gcm_frame_sequencer.sv
      - rtl/gcm_tag_check.sv
      - rtl/gcm_tag_engine.sv

  - target: test
    include_dirs:
      - include
    files:
      - verification/gcm_tag_engine_tb.sv

// ==== gcm_tag_engine.f ====
+incdir+include
rtl/gcm_types_pkg.sv
rtl/gcm_ctrl_pkg.sv
rtl/gf128_multiplier.sv
rtl/ghash_accumulator.sv
rtl/gcm_frame_sequencer.sv
rtl/gcm_tag_check.sv
rtl/gcm_tag_engine.sv
verification/gcm_tag_engine_tb.sv

// ==== rtl/gcm_ctrl_pkg.sv ====
`default_nettype none

// ==========================================================================
// Frame control definitions
// ==========================================================================
package gcm_ctrl_pkg;

    // Frame progress
    // IDLE waits for sop, TEXT absorbs blocks, LENGTH feeds the length word,
    // DONE covers the cycle before the tag is out
    typedef enum logic [1:0] {
        FRAME_IDLE   = 2'd0,
        FRAME_TEXT   = 2'd1,
        FRAME_LENGTH = 2'd2,
        FRAME_DONE   = 2'd3
    } frame_state_t;

    // Largest text block count per frame
    localparam int MAX_TEXT_BLOCKS = 1023;

endpackage

`default_nettype wire

// ==== rtl/gcm_frame_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

// Frame control for the tag engine
// Orders the GHASH input as AAD, text blocks, length word
module gcm_frame_sequencer
    import gcm_types_pkg::*, gcm_ctrl_pkg::*;
(
    input  wire logic        i_clock,
    input  wire logic        i_reset,
    input  wire logic        i_sop,
    input  wire logic        i_valid_text,
    input  wire gcm_block_t  i_text,
    input  wire gcm_block_t  i_aad,
    input  wire gcm_length_t i_length_aad,
    input  wire gcm_length_t i_length_text,
    input  wire logic        i_clear_fault,
    output logic             o_frame_start,
    output logic             o_ghash_start,
    output logic             o_ghash_valid,
    output gcm_block_t       o_ghash_block,
    output logic             o_length_fed,
    output logic             o_fault
);

    frame_state_t state;
    frame_state_t state_next;
    // Text blocks still to come
    gcm_count_t   block_count;
    // Block count taken from the text length
    gcm_count_t   count_start;
    // AAD length then text length
    gcm_block_t   length_word;
    logic         accept_start;
    logic         accept_text;
    logic         fault_event;
    logic         fault_flag;

    // ==========================================================================
    // Frame state machine
    // ==========================================================================

    // Start only counts when idle
    assign accept_start = i_sop && (state == FRAME_IDLE);
    assign accept_text  = i_valid_text && (state == FRAME_TEXT);
    // Bits to blocks, wraps at the counter width
    assign count_start  = i_length_text[LOG2_NB_BLOCK +: NB_COUNT];

    always_comb
    begin
        state_next = state;
        case (state)
            FRAME_IDLE:
            begin
                // Empty text goes straight to the length word
                if (accept_start && (count_start == '0))
                    state_next = FRAME_LENGTH;
                else if (accept_start)
                    state_next = FRAME_TEXT;
            end
            FRAME_TEXT:
            begin
                // Last block sampled, length word next
                if (accept_text && (block_count == gcm_count_t'(1)))
                    state_next = FRAME_LENGTH;
            end
            FRAME_LENGTH:
                state_next = FRAME_DONE;
            default:
                state_next = FRAME_IDLE;
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            state <= FRAME_IDLE;
        else
            state <= state_next;
    end

    // Block counter
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            block_count <= '0;
        else if (accept_start)
            block_count <= count_start;
        else if (accept_text)
            block_count <= block_count - gcm_count_t'(1);
    end

    // Length word, fed long after the sop cycle
    always_ff @(posedge i_clock)
    begin
        if (accept_start)
            length_word <= {i_length_aad, i_length_text};
    end

    // ==========================================================================
    // GHASH input select
    // ==========================================================================

    // AAD in the sop cycle, text in TEXT, length word in LENGTH
    always_comb
    begin
        case (state)
            FRAME_TEXT:   o_ghash_block = i_text;
            FRAME_LENGTH: o_ghash_block = length_word;
            default:      o_ghash_block = i_aad;
        endcase
    end

    assign o_ghash_valid = accept_start || accept_text || (state == FRAME_LENGTH);
    assign o_ghash_start = accept_start;
    assign o_frame_start = accept_start;
    assign o_length_fed  = (state == FRAME_LENGTH);

    // ==========================================================================
    // Protocol fault
    // ==========================================================================

    // Start during a frame, or text outside the text phase
    assign fault_event = (i_sop && (state != FRAME_IDLE))
                      || (i_valid_text && (state != FRAME_TEXT));

    // New fault beats the clear
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            fault_flag <= 1'b0;
        else if (fault_event)
            fault_flag <= 1'b1;
        else if (i_clear_fault)
            fault_flag <= 1'b0;
    end

    assign o_fault = fault_flag;

    // Counter is never zero while text is expected
    a_count_no_underflow: assert property (
        @(posedge i_clock) disable iff (i_reset)
        (state == FRAME_TEXT) |-> (block_count != '0)
    ) else $error("Text block counter underflow");

    a_length_single: assert property (
        @(posedge i_clock) disable iff (i_reset)
        o_length_fed |=> !o_length_fed
    ) else $error("Length word fed twice");

endmodule

`default_nettype wire

// ==== rtl/gcm_tag_check.sv ====
`timescale 1ns/10ps
`default_nettype none

// Final tag, tag-ready pulse and verify result
module gcm_tag_check
    import gcm_types_pkg::*;
(
    input  wire logic       i_clock,
    input  wire logic       i_reset,
    input  wire logic       i_frame_start,
    input  wire logic       i_length_fed,
    input  wire gcm_block_t i_ghash_value,
    input  wire gcm_block_t i_tag_mask,
    input  wire gcm_block_t i_tag,
    input  wire logic       i_verify,
    output gcm_block_t      o_tag,
    output logic            o_tag_ready,
    output logic            o_fail
);

    // Per-frame copies of E(K,J0) and the expected tag
    gcm_block_t mask_locked;
    gcm_block_t tag_locked;
    logic       verify_locked;
    // Y holds the length word from here on
    logic       length_fed_d;
    gcm_block_t tag_value;

    // ==========================================================================
    // Frame locks
    // ==========================================================================

    always_ff @(posedge i_clock)
    begin
        if (i_frame_start)
        begin
            mask_locked <= i_tag_mask;
            tag_locked  <= i_tag;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            verify_locked <= 1'b0;
        else if (i_frame_start)
            verify_locked <= i_verify;
    end

    // ==========================================================================
    // Tag output
    // ==========================================================================

    assign tag_value = i_ghash_value ^ mask_locked;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            length_fed_d <= 1'b0;
            o_tag_ready  <= 1'b0;
            o_tag        <= '0;
        end
        else
        begin
            length_fed_d <= i_length_fed;
            o_tag_ready  <= length_fed_d;
            if (length_fed_d)
                o_tag <= tag_value;
        end
    end

    // Cleared at start, updated with each new tag
    always_ff @(posedge i_clock)
    begin
        if (i_reset || i_frame_start)
            o_fail <= 1'b0;
        else if (length_fed_d)
            o_fail <= verify_locked && (tag_value != tag_locked);
    end

    a_ready_single: assert property (
        @(posedge i_clock) disable iff (i_reset)
        o_tag_ready |=> !o_tag_ready
    ) else $error("Tag ready held for two cycles");

endmodule

`default_nettype wire

// ==== rtl/gcm_tag_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

// GCM tag generation and check, one block per clock
module gcm_tag_engine
    import gcm_types_pkg::*;
(
    input  wire logic        i_clock,
    input  wire logic        i_reset,
    input  wire logic        i_sop,
    input  wire logic        i_valid_text,
    input  wire gcm_block_t  i_text,
    input  wire gcm_block_t  i_aad,
    input  wire gcm_length_t i_length_aad,
    input  wire gcm_length_t i_length_text,
    input  wire gcm_block_t  i_hash_subkey,
    input  wire gcm_block_t  i_tag_mask,
    input  wire gcm_block_t  i_tag,
    input  wire logic        i_verify,
    input  wire logic        i_clear_fault,
    output wire gcm_block_t  o_tag,
    output wire logic        o_tag_ready,
    output wire logic        o_fail,
    output wire logic        o_fault
);

    // Sequencer to accumulator
    logic       ghash_start;
    logic       ghash_valid;
    gcm_block_t ghash_block;
    // Accumulator to tag check
    gcm_block_t ghash_value;
    // Sequencer to tag check
    logic       frame_start;
    logic       length_fed;

    gcm_frame_sequencer u_gcm_frame_sequencer
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_sop         (i_sop),
        .i_valid_text  (i_valid_text),
        .i_text        (i_text),
        .i_aad         (i_aad),
        .i_length_aad  (i_length_aad),
        .i_length_text (i_length_text),
        .i_clear_fault (i_clear_fault),
        .o_frame_start (frame_start),
        .o_ghash_start (ghash_start),
        .o_ghash_valid (ghash_valid),
        .o_ghash_block (ghash_block),
        .o_length_fed  (length_fed),
        .o_fault       (o_fault)
    );

    ghash_accumulator u_ghash_accumulator
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_start       (ghash_start),
        .i_block_valid (ghash_valid),
        .i_block       (ghash_block),
        .i_hash_subkey (i_hash_subkey),
        .o_hash        (ghash_value)
    );

    gcm_tag_check u_gcm_tag_check
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_frame_start (frame_start),
        .i_length_fed  (length_fed),
        .i_ghash_value (ghash_value),
        .i_tag_mask    (i_tag_mask),
        .i_tag         (i_tag),
        .i_verify      (i_verify),
        .o_tag         (o_tag),
        .o_tag_ready   (o_tag_ready),
        .o_fail        (o_fail)
    );

endmodule

`default_nettype wire

// ==== rtl/gcm_types_pkg.sv ====
`default_nettype none

// ==========================================================================
// Widths and vector types of the GCM tag datapath
// ==========================================================================
package gcm_types_pkg;

    // Bits in one GCM block
    localparam int NB_BLOCK      = 128;
    // Each length field of the length word
    localparam int NB_LENGTH     = 64;
    // Bit length to block count
    localparam int LOG2_NB_BLOCK = 7;
    // Text block counter, up to 1023 blocks
    localparam int NB_COUNT      = 10;

    // Reduction constant, 11100001 followed by 120 zeros
    localparam logic [NB_BLOCK-1:0] GHASH_R = {8'hE1, 120'd0};

    // AAD, text, H, mask, tag and GHASH value
    typedef logic [NB_BLOCK-1:0]  gcm_block_t;
    // Bit length of AAD or text
    typedef logic [NB_LENGTH-1:0] gcm_length_t;
    // Text block count
    typedef logic [NB_COUNT-1:0]  gcm_count_t;

endpackage

`default_nettype wire

// ==== rtl/gf128_multiplier.sv ====
`timescale 1ns/10ps
`default_nettype none

// GF(2^128) product as used by GHASH
// Bit 127 of a vector is GCM bit 0, the coefficient of x^0
module gf128_multiplier
    import gcm_types_pkg::*;
(
    input  wire gcm_block_t i_operand_x,
    input  wire gcm_block_t i_operand_h,
    output gcm_block_t      o_product
);

    // Running sum and shifted copy of H
    gcm_block_t sum_z;
    gcm_block_t shift_v;

    // Right shift and reduce, one step per bit of X
    always_comb
    begin
        sum_z   = '0;
        shift_v = i_operand_h;
        for (int bit_idx = 0; bit_idx < NB_BLOCK; bit_idx++)
        begin
            // GCM bit bit_idx of X selects the current V
            if (i_operand_x[NB_BLOCK-1-bit_idx])
                sum_z = sum_z ^ shift_v;
            // Multiply V by x, reduce when x^127 falls off
            if (shift_v[0])
                shift_v = (shift_v >> 1) ^ GHASH_R;
            else
                shift_v = shift_v >> 1;
        end
    end

    assign o_product = sum_z;

endmodule

`default_nettype wire

// ==== rtl/ghash_accumulator.sv ====
`timescale 1ns/10ps
`default_nettype none

// Running GHASH value Y, one block per clock
module ghash_accumulator
    import gcm_types_pkg::*;
(
    input  wire logic       i_clock,
    input  wire logic       i_reset,
    input  wire logic       i_start,
    input  wire logic       i_block_valid,
    input  wire gcm_block_t i_block,
    input  wire gcm_block_t i_hash_subkey,
    output gcm_block_t      o_hash
);

    // Subkey held for the whole frame
    gcm_block_t h_locked;
    // Accumulated Y
    gcm_block_t hash_value;
    // Multiplier operands and result
    gcm_block_t operand_x;
    gcm_block_t operand_h;
    gcm_block_t product;

    // ==========================================================================
    // Operand select
    // ==========================================================================

    // First block of a frame starts from Y = 0
    assign operand_x = (i_start ? '0 : hash_value) ^ i_block;
    // Lock is not written yet at start, take H directly
    assign operand_h = i_start ? i_hash_subkey : h_locked;

    gf128_multiplier u_gf128_multiplier
    (
        .i_operand_x (operand_x),
        .i_operand_h (operand_h),
        .o_product   (product)
    );

    // ==========================================================================
    // Registers
    // ==========================================================================

    always_ff @(posedge i_clock)
    begin
        if (i_start)
            h_locked <= i_hash_subkey;
    end

    // Y <= (Y xor X) * H
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            hash_value <= '0;
        else if (i_block_valid)
            hash_value <= product;
    end

    assign o_hash = hash_value;

    // Sequencer always pairs the start with the AAD block
    a_start_with_valid: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_start |-> i_block_valid
    ) else $error("GHASH start without a block");

endmodule

`default_nettype wire

// ==== include/gcm_tb_ref.svh ====
`ifndef GCM_TB_REF_SVH
`define GCM_TB_REF_SVH

// Reference model for the tag engine
// Included inside a module that imports gcm_types_pkg

// Generator state
int unsigned lcg_state = 32'd36542;

// Field product by Horner over the bits of X
// Each step multiplies the partial result by x and adds H
function automatic gcm_block_t gf_multiply(input gcm_block_t x, input gcm_block_t h);
    gcm_block_t acc;
    acc = '0;
    for (int j = 0; j < NB_BLOCK; j++)
    begin
        acc = acc[0] ? ((acc >> 1) ^ GHASH_R) : (acc >> 1);
        if (x[j])
            acc = acc ^ h;
    end
    return acc;
endfunction

// Masked GHASH over the AAD, the text blocks and the length word
function automatic gcm_block_t compute_tag(input gcm_block_t aad, input gcm_block_t text[$],
                                           input gcm_length_t len_aad,
                                           input gcm_length_t len_text,
                                           input gcm_block_t h, input gcm_block_t mask);
    gcm_block_t y;
    y = gf_multiply(aad, h);
    foreach (text[i])
        y = gf_multiply(y ^ text[i], h);
    y = gf_multiply(y ^ {len_aad, len_text}, h);
    return y ^ mask;
endfunction

// 32-bit LCG draw
function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// Full block from four draws
function automatic gcm_block_t random_block();
    gcm_block_t blk;
    blk = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
    return blk;
endfunction

`endif

// ==== verification/gcm_tag_engine_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module gcm_tag_engine_tb
    import gcm_types_pkg::*, gcm_ctrl_pkg::*;
();

    `include "gcm_tb_ref.svh"

    // Cycles any single wait may take
    localparam int WAIT_LIMIT = 200;

    logic        i_clock;
    logic        i_reset;
    logic        i_sop;
    logic        i_valid_text;
    gcm_block_t  i_text;
    gcm_block_t  i_aad;
    gcm_length_t i_length_aad;
    gcm_length_t i_length_text;
    gcm_block_t  i_hash_subkey;
    gcm_block_t  i_tag_mask;
    gcm_block_t  i_tag;
    logic        i_verify;
    logic        i_clear_fault;
    wire gcm_block_t o_tag;
    wire logic   o_tag_ready;
    wire logic   o_fail;
    wire logic   o_fault;

    // Rising edges seen so far
    int          edge_count = 0;
    // Expected results in arrival order
    int          exp_edge_q[$];
    gcm_block_t  exp_tag_q[$];
    logic        exp_fail_q[$];

    gcm_tag_engine dut
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_sop         (i_sop),
        .i_valid_text  (i_valid_text),
        .i_text        (i_text),
        .i_aad         (i_aad),
        .i_length_aad  (i_length_aad),
        .i_length_text (i_length_text),
        .i_hash_subkey (i_hash_subkey),
        .i_tag_mask    (i_tag_mask),
        .i_tag         (i_tag),
        .i_verify      (i_verify),
        .i_clear_fault (i_clear_fault),
        .o_tag         (o_tag),
        .o_tag_ready   (o_tag_ready),
        .o_fail        (o_fail),
        .o_fault       (o_fault)
    );

    // ==========================================================================
    // Clock and helpers
    // ==========================================================================

    initial
    begin
        i_clock = 1'b0;
        forever
            #2 i_clock = ~i_clock;
    end

    always @(posedge i_clock)
        edge_count <= edge_count + 1;

    // Next rising edge plus the drive delay
    task automatic step();
        @(posedge i_clock);
        #1;
    endtask

    task automatic check_block(input gcm_block_t actual, input gcm_block_t expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Until the checker has seen every pending tag
    task automatic wait_tags_drained();
        int waited;
        waited = 0;
        while (exp_tag_q.size() != 0)
        begin
            if (waited >= WAIT_LIMIT)
            begin
                $display("Timed out waiting for o_tag_ready after %0d cycles", waited);
                $display("Test failures found");
                $fatal(1, "Timeout");
            end
            step();
            waited++;
        end
    endtask

    // One frame of n_blocks text blocks with random gaps
    task automatic run_frame(input int n_blocks, input logic verify, input logic flip_tag,
                             input logic mid_sop);
        gcm_block_t  h;
        gcm_block_t  mask;
        gcm_block_t  aad;
        gcm_block_t  exp_tag;
        gcm_block_t  all_ones;
        gcm_block_t  text_q[$];
        gcm_length_t len_aad;
        gcm_length_t len_text;
        int          aad_bits;
        int          gap;
        if (n_blocks > MAX_TEXT_BLOCKS)
            n_blocks = MAX_TEXT_BLOCKS;
        all_ones = '1;
        h        = random_block();
        mask     = random_block();
        aad_bits = int'(lcg_next() % 128) + 1;
        // Keep the first aad_bits bits in GCM order and zero the rest
        aad      = random_block() & ~(all_ones >> aad_bits);
        len_aad  = gcm_length_t'(aad_bits);
        len_text = gcm_length_t'(n_blocks) << LOG2_NB_BLOCK;
        for (int i = 0; i < n_blocks; i++)
            text_q.push_back(random_block());
        exp_tag = compute_tag(aad, text_q, len_aad, len_text, h, mask);

        // Start of frame with its per-frame values
        i_sop         = 1'b1;
        i_aad         = aad;
        i_length_aad  = len_aad;
        i_length_text = len_text;
        i_hash_subkey = h;
        i_tag_mask    = mask;
        i_tag         = flip_tag ? exp_tag ^ (gcm_block_t'(1) << (lcg_next() % 128))
                                 : exp_tag;
        i_verify      = verify;
        step();
        i_sop = 1'b0;
        check_flag(o_fail, 1'b0, "o_fail after start");
        if (n_blocks == 0)
        begin
            exp_edge_q.push_back(edge_count + 2);
            exp_tag_q.push_back(exp_tag);
            exp_fail_q.push_back(verify && flip_tag);
        end
        // Per-frame values only count in the sop cycle
        i_hash_subkey = random_block();
        i_tag_mask    = random_block();
        i_aad         = random_block();
        i_tag         = random_block();
        i_verify      = ~verify;

        for (int i = 0; i < n_blocks; i++)
        begin
            gap = int'(lcg_next() % 4);
            repeat (gap)
                step();
            // Stray start inside the frame is ignored but flagged
            if (mid_sop && (i == 0))
            begin
                i_sop = 1'b1;
                step();
                i_sop = 1'b0;
                check_flag(o_fault, 1'b1, "o_fault after mid-frame sop");
            end
            i_valid_text = 1'b1;
            i_text       = text_q[i];
            step();
            i_valid_text = 1'b0;
            i_text       = random_block();
            if (i == n_blocks - 1)
            begin
                exp_edge_q.push_back(edge_count + 2);
                exp_tag_q.push_back(exp_tag);
                exp_fail_q.push_back(verify && flip_tag);
            end
        end
        wait_tags_drained();
    endtask

    // ==========================================================================
    // Checking process
    // ==========================================================================

    initial
    begin : compare_process
        logic ready_expected;
        forever
        begin
            @(negedge i_clock);
            if (!i_reset)
            begin
                ready_expected = (exp_edge_q.size() != 0) && (exp_edge_q[0] == edge_count);
                check_flag(o_tag_ready, ready_expected, "o_tag_ready");
                if (ready_expected)
                begin
                    check_block(o_tag, exp_tag_q[0], "o_tag");
                    check_flag(o_fail, exp_fail_q[0], "o_fail");
                    void'(exp_edge_q.pop_front());
                    void'(exp_tag_q.pop_front());
                    void'(exp_fail_q.pop_front());
                end
            end
        end
    end

    // ==========================================================================
    // Stimulus
    // ==========================================================================

    initial
    begin
        i_reset       = 1'b1;
        i_sop         = 1'b0;
        i_valid_text  = 1'b0;
        i_text        = '0;
        i_aad         = '0;
        i_length_aad  = '0;
        i_length_text = '0;
        i_hash_subkey = '0;
        i_tag_mask    = '0;
        i_tag         = '0;
        i_verify      = 1'b0;
        i_clear_fault = 1'b0;
        repeat (16)
            step();
        i_reset = 1'b0;
        step();

        // Quiet outputs before any frame
        check_flag(o_tag_ready, 1'b0, "o_tag_ready after reset");
        check_flag(o_fail, 1'b0, "o_fail after reset");
        check_flag(o_fault, 1'b0, "o_fault after reset");
        check_block(o_tag, '0, "o_tag after reset");

        // Empty text first and then random frames
        run_frame(0, 1'b0, 1'b0, 1'b0);
        for (int f = 0; f < 8; f++)
            run_frame(int'(lcg_next() % 8) + 1, 1'b0, 1'b0, 1'b0);
        check_flag(o_fault, 1'b0, "o_fault after clean frames");

        // Wrong expected tag without verify leaves o_fail low
        run_frame(3, 1'b0, 1'b1, 1'b0);

        // Verify mode with good and bad tags, and a start clears the fail
        run_frame(3, 1'b1, 1'b0, 1'b0);
        run_frame(4, 1'b1, 1'b1, 1'b0);
        run_frame(2, 1'b1, 1'b0, 1'b0);

        // Faults
        run_frame(5, 1'b0, 1'b0, 1'b1);
        i_clear_fault = 1'b1;
        step();
        i_clear_fault = 1'b0;
        check_flag(o_fault, 1'b0, "o_fault after clear");
        i_valid_text = 1'b1;
        i_text       = random_block();
        step();
        i_valid_text = 1'b0;
        check_flag(o_fault, 1'b1, "o_fault after idle text");
        i_clear_fault = 1'b1;
        step();
        i_clear_fault = 1'b0;
        check_flag(o_fault, 1'b0, "o_fault after second clear");
        repeat (4)
            step();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
